/* fetch_testdata.txt */
# cmd  value  expected_addr  name
# R value is the resteer address, C value is the consume length in bytes
R 00001000 00001000 start_aligned
C 4 00001004 short_step
C f 00001013 long_step
C c 0000101f tail_byte
C 1 00001020 line_cross
C e 0000102e near_end
C 2 00001030 exact_cross
R 0000207d 0000207d resteer_mid
C 2 0000207f last_byte
C f 0000208e straddle
R 00003000 00003000 resteer_abandoned
R 0000400c 0000400c resteer_again
C 7 00004013 cross_after_resteer
C c 0000401f end_of_line
R 0ffffff8 0ffffff8 high_addr
C 8 10000000 high_cross
R 00005007 00005007 resteer_outstanding
C 6 0000500d final_step

/* tb.f */
fetch_pkg.sv
fetch_if.sv
fetch_ctrl.sv
line_req.sv
ibuff.sv
packet_align.sv
fetch_top.sv
fetch_properties.sv
tb_fetch.sv

/* run.sh */
#!/bin/sh
# build and run the fetch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch -f tb.f -o tb_fetch_sim

./obj_dir/tb_fetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
exit 1

/* tb_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_fetch;
    import fetch_pkg::*;

    localparam int          HALF_PERIOD  = 20;
    localparam int          RESET_CYCLES = 10;
    localparam int          CMD_CYCLES   = 200;
    localparam int unsigned SEED         = 32'h694bcf62;

    logic              clk = 1'b0;
    logic              rst_i;
    logic              resteer_i;
    logic [ADDR_W-1:0] resteer_addr_i;
    logic              consume_i;
    logic [LEN_W-1:0]  consume_len_i;
    logic              req_valid_o;
    logic [LNUM_W-1:0] req_lnum_o;
    logic              resp_valid_i;
    logic [LINE_W-1:0] resp_data_i;
    logic              packet_valid_o;
    logic [LINE_W-1:0] packet_o;
    logic [ADDR_W-1:0] packet_addr_o;

    // commands from the data file
    string             cmd_q [$];
    logic [31:0]       val_q [$];
    logic [31:0]       exp_q [$];
    string             name_q [$];
    // memory model requests in arrival order
    logic [LNUM_W-1:0] mreq_q [$];
    int unsigned       mdue_q [$];
    // packets seen by the decode model
    logic [ADDR_W-1:0] pkt_addr_q [$];
    logic [LINE_W-1:0] pkt_data_q [$];

    // line the next request must ask for
    logic [LNUM_W-1:0] next_req_lnum = '0;

    int unsigned cyc = 0;
    int unsigned cycle_limit = 0;
    int unsigned last_due = 0;
    int          mem_out = 0;
    int          pkt_out = 0;
    int          mismatches = 0;
    int          faults = 0;
    int          mon_faults = 0;

    always #(HALF_PERIOD) clk = ~clk;

    fetch_top dut_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .resteer_i      (resteer_i),
        .resteer_addr_i (resteer_addr_i),
        .consume_i      (consume_i),
        .consume_len_i  (consume_len_i),
        .req_valid_o    (req_valid_o),
        .req_lnum_o     (req_lnum_o),
        .resp_valid_i   (resp_valid_i),
        .resp_data_i    (resp_data_i),
        .packet_valid_o (packet_valid_o),
        .packet_o       (packet_o),
        .packet_addr_o  (packet_addr_o)
    );

    //////////////////////////////
    // memory byte rule
    //////////////////////////////
    function automatic logic [LINE_W-1:0] bytes_from(input logic [ADDR_W-1:0] base);
        logic [LINE_W-1:0] data;
        logic [ADDR_W-1:0] a;
        int                i;
        for (i = 0; i < LINE_BYTES; i++) begin
            a = base + ADDR_W'(i);
            data[8*i +: 8] = a[7:0] ^ MEM_XOR;
        end
        return data;
    endfunction

    task automatic load_commands();
        int          fd;
        int          n;
        string       line;
        string       cmd;
        string       name;
        logic [31:0] value;
        logic [31:0] expect_addr;
        fd = $fopen("fetch_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open fetch_testdata.txt");
            faults++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %h %s", cmd, value, expect_addr, name);
            if (n != 4) begin
                $display("unreadable line in fetch_testdata.txt: %s", line);
                faults++;
            end else begin
                cmd_q.push_back(cmd);
                val_q.push_back(value);
                exp_q.push_back(expect_addr);
                name_q.push_back(name);
            end
        end
        $fclose(fd);
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic drive_resteer(input logic [ADDR_W-1:0] addr);
        @(negedge clk);
        resteer_i      = 1'b1;
        resteer_addr_i = addr;
        // anything queued so far is from the old stream
        pkt_addr_q.delete();
        pkt_data_q.delete();
        @(negedge clk);
        resteer_i = 1'b0;
    endtask

    task automatic drive_consume(input logic [31:0] len);
        @(negedge clk);
        consume_i     = 1'b1;
        consume_len_i = LEN_W'(len);
        @(negedge clk);
        consume_i = 1'b0;
    endtask

    task automatic take_packet(input logic [ADDR_W-1:0] exp_addr, input string name);
        logic [ADDR_W-1:0] got_addr;
        logic [LINE_W-1:0] got_data;
        logic [LINE_W-1:0] exp_data;
        while (pkt_addr_q.size() == 0) begin
            @(negedge clk);
        end
        got_addr = pkt_addr_q.pop_front();
        got_data = pkt_data_q.pop_front();
        exp_data = bytes_from(exp_addr);
        assert (got_addr == exp_addr) else begin
            $display("Mismatch %s address: expected %h, actual %h", name, exp_addr, got_addr);
            mismatches++;
        end
        assert (got_data == exp_data) else begin
            $display("Mismatch %s bytes: expected %h, actual %h", name, exp_data, got_data);
            mismatches++;
        end
    endtask

    // decode holds the credit a short while or much longer
    task automatic decode_wait();
        if ($urandom % 4 == 0) begin
            idle(8 + int'($urandom % 12));
        end else begin
            idle(int'($urandom % 3));
        end
        assert (pkt_addr_q.size() == 0) else begin
            $display("a second packet came for one pointer value");
            faults++;
        end
    endtask

    //////////////////////////////
    // memory responses
    //////////////////////////////
    initial begin : mem_driver
        resp_valid_i = 1'b0;
        resp_data_i  = '0;
        forever begin
            @(negedge clk);
            resp_valid_i = 1'b0;
            if (mreq_q.size() != 0 && mdue_q[0] <= cyc + 1) begin
                resp_valid_i = 1'b1;
                resp_data_i  = bytes_from({mreq_q.pop_front(), 4'h0});
                void'(mdue_q.pop_front());
            end
        end
    end

    // request, response and packet bookkeeping
    always @(posedge clk) begin : monitor
        int unsigned due;
        cyc = cyc + 1;
        if (rst_i) begin
            mem_out = 0;
            pkt_out = 0;
        end else begin
            if (req_valid_o) begin
                assert (req_lnum_o == next_req_lnum) else begin
                    $display("Mismatch line_request: expected %h, actual %h",
                             next_req_lnum, req_lnum_o);
                    mismatches++;
                end
                next_req_lnum = next_req_lnum + 1'b1;
                due = cyc + 1 + ($urandom % 6);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                mreq_q.push_back(req_lnum_o);
                mdue_q.push_back(due);
                mem_out++;
            end
            if (resp_valid_i) begin
                mem_out--;
            end
            assert (mem_out <= MEM_CREDITS) else begin
                $display("more than %0d line requests outstanding", MEM_CREDITS);
                mon_faults++;
            end
            if (resteer_i) begin
                pkt_out = 0;
                // fetch restarts at the line of the new address
                next_req_lnum = resteer_addr_i[ADDR_W-1:BIP_W];
            end else begin
                if (consume_i) begin
                    pkt_out--;
                end
                if (packet_valid_o) begin
                    pkt_addr_q.push_back(packet_addr_o);
                    pkt_data_q.push_back(packet_o);
                    pkt_out++;
                end
            end
            assert (pkt_out <= PKT_CREDITS) else begin
                $display("more than %0d packets outstanding", PKT_CREDITS);
                mon_faults++;
            end
        end
        if (cyc >= cycle_limit) begin
            $display("timeout after %0d cycles, a packet or response never came", cyc);
            $display("errors: %0d mismatches, %0d other", mismatches, faults + mon_faults + 1);
            $display("Simulation failed");
            $finish;
        end
    end

    //////////////////////////////
    // command sequence
    //////////////////////////////
    initial begin : stimulus
        int                k;
        string             prev_cmd;
        logic              need_pkt;
        logic [ADDR_W-1:0] exp_addr;
        logic [ADDR_W-1:0] model_addr;
        string             exp_name;
        void'($urandom(SEED));
        rst_i          = 1'b1;
        resteer_i      = 1'b0;
        resteer_addr_i = '0;
        consume_i      = 1'b0;
        consume_len_i  = '0;
        load_commands();
        cycle_limit = RESET_CYCLES + 20 + CMD_CYCLES * cmd_q.size();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_i    = 1'b0;
        prev_cmd = "";
        need_pkt = 1'b0;
        exp_addr = '0;
        exp_name = "";
        for (k = 0; k < cmd_q.size(); k++) begin
            if (cmd_q[k] == "R") begin
                if (need_pkt && prev_cmd == "R") begin
                    // abandon the stream while its lines are still in flight
                    idle(1 + int'($urandom % 3));
                end else begin
                    if (need_pkt) begin
                        take_packet(exp_addr, exp_name);
                    end
                    idle(int'($urandom % 3));
                end
                assert (exp_q[k] == val_q[k]) else begin
                    $display("%s: first packet must start at the resteer address", name_q[k]);
                    faults++;
                end
                drive_resteer(val_q[k]);
                exp_addr = val_q[k];
            end else if (cmd_q[k] == "C") begin
                if (need_pkt) begin
                    take_packet(exp_addr, exp_name);
                end
                model_addr = exp_addr + val_q[k];
                assert (exp_q[k] == model_addr) else begin
                    $display("%s: data file address disagrees with pointer plus length",
                             name_q[k]);
                    faults++;
                end
                decode_wait();
                drive_consume(val_q[k]);
                exp_addr = model_addr;
            end else begin
                $display("unknown command %s in the data file", cmd_q[k]);
                faults++;
            end
            need_pkt = 1'b1;
            exp_name = name_q[k];
            prev_cmd = cmd_q[k];
        end
        if (need_pkt) begin
            take_packet(exp_addr, exp_name);
        end
        idle(8);
        assert (pkt_addr_q.size() == 0) else begin
            $display("a packet came without a consume before it");
            faults++;
        end
        $display("errors: %0d mismatches, %0d other", mismatches, faults + mon_faults);
        if (mismatches + faults + mon_faults == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* fetch_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_properties (
    input logic clk,
    input logic rst_i,
    input logic req_valid_i,
    input logic resp_valid_i,
    input logic packet_valid_i,
    input logic flush_i,
    input logic fill_valid_i
);
    import fetch_pkg::*;

    // line requests minus responses
    logic [MCRED_W-1:0] in_flight;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + MCRED_W'(req_valid_i) - MCRED_W'(resp_valid_i);
        end
    end

    a_req_needs_credit: assert property (@(posedge clk) disable iff (rst_i)
        (in_flight == MCRED_W'(MEM_CREDITS)) |-> !req_valid_i)
        else $error("line request issued with all memory credits in use");

    a_packet_gap: assert property (@(posedge clk) disable iff (rst_i)
        packet_valid_i |=> !packet_valid_i)
        else $error("packet valid held for two cycles");

    a_no_fill_after_flush: assert property (@(posedge clk) disable iff (rst_i)
        flush_i |=> !fill_valid_i)
        else $error("buffer filled in the cycle after a flush");

endmodule

bind fetch_top fetch_properties props_i (
    .clk            (clk),
    .rst_i          (rst_i),
    .req_valid_i    (req_valid_o),
    .resp_valid_i   (resp_valid_i),
    .packet_valid_i (packet_valid_o),
    .flush_i        (flush),
    .fill_valid_i   (fill_bus.fill_valid)
);

`default_nettype wire

/* fetch_top.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
    input  logic                         clk,
    input  logic                         rst_i,

    // redirect and decode handshake
    input  logic                         resteer_i,
    input  logic [fetch_pkg::ADDR_W-1:0] resteer_addr_i,
    input  logic                         consume_i,
    input  logic [fetch_pkg::LEN_W-1:0]  consume_len_i,

    // memory line port
    output logic                         req_valid_o,
    output logic [fetch_pkg::LNUM_W-1:0] req_lnum_o,
    input  logic                         resp_valid_i,
    input  logic [fetch_pkg::LINE_W-1:0] resp_data_i,

    // packet to decode
    output logic                         packet_valid_o,
    output logic [fetch_pkg::LINE_W-1:0] packet_o,
    output logic [fetch_pkg::ADDR_W-1:0] packet_addr_o
);
    import fetch_pkg::*;

    fill_if   fill_bus ();
    window_if win_bus ();

    fip_u              resteer_fip;
    fip_u              emit_addr;
    logic              want;
    logic [LNUM_W-1:0] want_lnum;
    logic              issue;
    logic              flush;
    logic              retire;
    logic [SLOT_W-1:0] retire_slot;
    logic              emit;

    assign resteer_fip.addr = resteer_addr_i;

    //////////////////////////////
    // control
    //////////////////////////////
    fetch_ctrl u_ctrl (
        .clk            (clk),
        .rst_i          (rst_i),
        .resteer_i      (resteer_i),
        .resteer_addr_i (resteer_fip),
        .consume_i      (consume_i),
        .consume_len_i  (consume_len_i),
        .want_o         (want),
        .want_lnum_o    (want_lnum),
        .issue_i        (issue),
        .flush_o        (flush),
        .retire_o       (retire),
        .retire_slot_o  (retire_slot),
        .win            (win_bus.ctrl),
        .emit_o         (emit),
        .emit_addr_o    (emit_addr)
    );

    //////////////////////////////
    // datapath
    //////////////////////////////
    line_req u_req (
        .clk          (clk),
        .rst_i        (rst_i),
        .want_i       (want),
        .want_lnum_i  (want_lnum),
        .issue_o      (issue),
        .flush_i      (flush),
        .req_valid_o  (req_valid_o),
        .req_lnum_o   (req_lnum_o),
        .resp_valid_i (resp_valid_i),
        .resp_data_i  (resp_data_i),
        .fill         (fill_bus.src)
    );

    // emit address is the live fetch pointer
    ibuff u_buf (
        .clk           (clk),
        .rst_i         (rst_i),
        .fill          (fill_bus.dst),
        .flush_i       (flush),
        .retire_i      (retire),
        .retire_slot_i (retire_slot),
        .ptr_lnum_i    (emit_addr.f.lnum),
        .win           (win_bus.src)
    );

    packet_align u_align (
        .clk            (clk),
        .rst_i          (rst_i),
        .win            (win_bus.align),
        .emit_i         (emit),
        .emit_addr_i    (emit_addr),
        .packet_valid_o (packet_valid_o),
        .packet_o       (packet_o),
        .packet_addr_o  (packet_addr_o)
    );

endmodule

`default_nettype wire

/* packet_align.sv */
`timescale 1ns/100ps
`default_nettype none

module packet_align (
    input  logic                         clk,
    input  logic                         rst_i,
    window_if.align                      win,
    input  logic                         emit_i,
    input  fetch_pkg::fip_u              emit_addr_i,
    output logic                         packet_valid_o,
    output logic [fetch_pkg::LINE_W-1:0] packet_o,
    output logic [fetch_pkg::ADDR_W-1:0] packet_addr_o
);
    import fetch_pkg::*;

    // byte 0 of the pair is byte 0 of the pointer line
    logic [2*LINE_W-1:0] pair;
    logic [2*LINE_W-1:0] shifted;
    logic [LINE_W-1:0]   rotated;
    logic [BIP_W+2:0]    shamt;

    assign pair    = {win.hi_line, win.lo_line};
    assign shamt   = {emit_addr_i.f.bip, 3'b000};
    assign shifted = pair >> shamt;
    // bytes bip .. bip+15, lowest first
    assign rotated = shifted[LINE_W-1:0];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            packet_valid_o <= 1'b0;
        end else begin
            packet_valid_o <= emit_i;
        end
    end

    // packet payload and address, held between emits
    always_ff @(posedge clk) begin
        if (emit_i) begin
            packet_o      <= rotated;
            packet_addr_o <= emit_addr_i.addr;
        end
    end

endmodule

`default_nettype wire

/* ibuff.sv */
`timescale 1ns/100ps
`default_nettype none

module ibuff (
    input  logic                         clk,
    input  logic                         rst_i,
    fill_if.dst                          fill,
    input  logic                         flush_i,
    input  logic                         retire_i,
    input  logic [fetch_pkg::SLOT_W-1:0] retire_slot_i,
    input  logic [fetch_pkg::LNUM_W-1:0] ptr_lnum_i,
    window_if.src                        win
);
    import fetch_pkg::*;

    logic [LINE_W-1:0] line_q [SLOTS];
    logic [LNUM_W-1:0] tag_q  [SLOTS];
    logic [SLOTS-1:0]  valid_q;

    logic [SLOT_W-1:0] fill_slot;
    logic [SLOT_W-1:0] lo_slot;
    logic [SLOT_W-1:0] hi_slot;
    logic [LNUM_W-1:0] hi_lnum;

    assign fill_slot = fill.fill_lnum[SLOT_W-1:0];
    assign hi_lnum   = ptr_lnum_i + 1'b1;
    assign lo_slot   = ptr_lnum_i[SLOT_W-1:0];
    assign hi_slot   = hi_lnum[SLOT_W-1:0];

    //////////////////////////////
    // slot state
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            valid_q <= '0;
        end else begin
            if (fill.fill_valid) begin
                valid_q[fill_slot] <= 1'b1;
            end
            // the retired line is never the one being filled
            if (retire_i) begin
                valid_q[retire_slot_i] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill.fill_valid) begin
            line_q[fill_slot] <= fill.fill_data;
            tag_q[fill_slot]  <= fill.fill_lnum;
        end
    end

    //////////////////////////////
    // window at the pointer
    //////////////////////////////
    assign win.lo_line = line_q[lo_slot];
    assign win.hi_line = line_q[hi_slot];

    // slot holds the wanted line only if the tag agrees
    assign win.lo_valid = valid_q[lo_slot] && (tag_q[lo_slot] == ptr_lnum_i);
    assign win.hi_valid = valid_q[hi_slot] && (tag_q[hi_slot] == hi_lnum);

endmodule

`default_nettype wire

/* line_req.sv */
`timescale 1ns/100ps
`default_nettype none

module line_req (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         want_i,
    input  logic [fetch_pkg::LNUM_W-1:0] want_lnum_i,
    output logic                         issue_o,
    input  logic                         flush_i,
    output logic                         req_valid_o,
    output logic [fetch_pkg::LNUM_W-1:0] req_lnum_o,
    input  logic                         resp_valid_i,
    input  logic [fetch_pkg::LINE_W-1:0] resp_data_i,
    fill_if.src                          fill
);
    import fetch_pkg::*;

    // line numbers of outstanding requests, oldest at rd_ptr
    logic [LNUM_W-1:0]  pend_q [MEM_CREDITS];
    logic [MQ_W-1:0]    wr_ptr;
    logic [MQ_W-1:0]    rd_ptr;
    logic [MCRED_W-1:0] credits;
    logic [MCRED_W-1:0] pending;
    logic [MCRED_W-1:0] drop_cnt;
    logic               dropping;

    assign pending  = MCRED_W'(MEM_CREDITS) - credits;
    assign dropping = drop_cnt != '0;

    // no new request in the flush cycle
    assign issue_o     = want_i && !flush_i && (credits != '0);
    assign req_valid_o = issue_o;
    assign req_lnum_o  = want_lnum_i;

    // responses from before a flush never reach the buffer
    assign fill.fill_valid = resp_valid_i && !dropping && !flush_i;
    assign fill.fill_lnum  = pend_q[rd_ptr];
    assign fill.fill_data  = resp_data_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            credits  <= MCRED_W'(MEM_CREDITS);
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            drop_cnt <= '0;
        end else begin
            credits <= credits - MCRED_W'(issue_o) + MCRED_W'(resp_valid_i);
            if (issue_o) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (resp_valid_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // everything still in flight belongs to the old stream
            if (flush_i) begin
                drop_cnt <= pending - MCRED_W'(resp_valid_i);
            end else if (resp_valid_i && dropping) begin
                drop_cnt <= drop_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_o) begin
            pend_q[wr_ptr] <= want_lnum_i;
        end
    end

endmodule

`default_nettype wire

/* fetch_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_ctrl (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       resteer_i,
    input  fetch_pkg::fip_u            resteer_addr_i,
    input  logic                       consume_i,
    input  logic [fetch_pkg::LEN_W-1:0] consume_len_i,
    output logic                       want_o,
    output logic [fetch_pkg::LNUM_W-1:0] want_lnum_o,
    input  logic                       issue_i,
    output logic                       flush_o,
    output logic                       retire_o,
    output logic [fetch_pkg::SLOT_W-1:0] retire_slot_o,
    window_if.ctrl                     win,
    output logic                       emit_o,
    output fetch_pkg::fip_u            emit_addr_o
);
    import fetch_pkg::*;

    fip_u              ptr;
    fip_u              ptr_next;
    logic [LNUM_W-1:0] plan_lnum;
    logic [LNUM_W-1:0] plan_dist;
    logic [PCRED_W-1:0] pcred;
    logic              emitted;
    logic              active;
    logic              step;
    logic              crossing;

    //////////////////////////////
    // pointer advance
    //////////////////////////////
    assign step     = consume_i && !resteer_i;
    assign ptr_next.addr = ptr.addr + ADDR_W'(consume_len_i);
    // lengths stay below a line, so at most one line is left behind
    assign crossing = ptr_next.f.lnum != ptr.f.lnum;

    assign retire_o      = step && crossing;
    assign retire_slot_o = ptr.f.lnum[SLOT_W-1:0];
    assign flush_o       = resteer_i;

    //////////////////////////////
    // request planning
    //////////////////////////////
    // pointer line up to three lines ahead
    assign plan_dist   = plan_lnum - ptr.f.lnum;
    assign want_o      = active && !resteer_i && (plan_dist < LNUM_W'(SLOTS));
    assign want_lnum_o = plan_lnum;

    //////////////////////////////
    // emit decision
    //////////////////////////////
    assign emit_o = active && !resteer_i && !consume_i && !emitted &&
                    (pcred != '0) && win.lo_valid && win.hi_valid;
    assign emit_addr_o = ptr;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ptr.addr  <= '0;
            plan_lnum <= '0;
            pcred     <= PCRED_W'(PKT_CREDITS);
            emitted   <= 1'b0;
            active    <= 1'b0;
        end else if (resteer_i) begin
            ptr       <= resteer_addr_i;
            plan_lnum <= resteer_addr_i.f.lnum;
            pcred     <= PCRED_W'(PKT_CREDITS);
            emitted   <= 1'b0;
            active    <= 1'b1;
        end else begin
            if (issue_i) begin
                plan_lnum <= plan_lnum + 1'b1;
            end
            if (consume_i) begin
                ptr <= ptr_next;
            end
            // one credit per packet, returned by its consume
            pcred <= pcred - PCRED_W'(emit_o) + PCRED_W'(consume_i);
            if (consume_i) begin
                emitted <= 1'b0;
            end else if (emit_o) begin
                emitted <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* fetch_if.sv */
`timescale 1ns/100ps
`default_nettype none

// line fill from the request tracker into the buffer
interface fill_if;
    import fetch_pkg::*;

    logic              fill_valid;
    logic [LNUM_W-1:0] fill_lnum;
    logic [LINE_W-1:0] fill_data;

    modport src (output fill_valid, output fill_lnum, output fill_data);
    modport dst (input fill_valid, input fill_lnum, input fill_data);
    // observe only, no data needed
    modport mon (input fill_valid, input fill_lnum);
endinterface

// two-line window at the fetch pointer
interface window_if;
    import fetch_pkg::*;

    logic [LINE_W-1:0] lo_line;
    logic [LINE_W-1:0] hi_line;
    logic              lo_valid;
    logic              hi_valid;

    modport src (output lo_line, output hi_line, output lo_valid, output hi_valid);
    modport align (input lo_line, input hi_line);
    modport ctrl (input lo_valid, input hi_valid);
endinterface

`default_nettype wire

/* fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    //////////////////////////////
    // line and address geometry
    //////////////////////////////
    localparam int LINE_BYTES = 16;
    localparam int LINE_W     = 128;
    localparam int ADDR_W     = 32;
    localparam int LNUM_W     = 28;
    localparam int BIP_W      = 4;

    // instruction buffer depth, slot is lnum modulo SLOTS
    localparam int SLOTS  = 4;
    localparam int SLOT_W = $clog2(SLOTS);

    //////////////////////////////
    // flow control
    //////////////////////////////
    localparam int MEM_CREDITS = 4;
    localparam int MCRED_W     = $clog2(MEM_CREDITS + 1);
    // index into the outstanding request queue
    localparam int MQ_W        = $clog2(MEM_CREDITS);

    localparam int PKT_CREDITS = 2;
    localparam int PCRED_W     = $clog2(PKT_CREDITS + 1);

    // consume length, 1..15 bytes
    localparam int LEN_W = 5;

    // memory content rule: byte a holds a[7:0] ^ MEM_XOR
    localparam logic [7:0] MEM_XOR = 8'h5A;

    //////////////////////////////
    // fetch address
    //////////////////////////////
    typedef struct packed {
        logic [LNUM_W-1:0] lnum;
        logic [BIP_W-1:0]  bip;
    } fip_s;

    // same 32 bits, flat or split into line and byte pointer
    typedef union packed {
        logic [ADDR_W-1:0] addr;
        fip_s              f;
    } fip_u;

endpackage

`default_nettype wire
